/* logic/rv32Pkg.sv */
package rv32Pkg;

    //////////////////////////////////////////////////////////////////////
    // widths
    //////////////////////////////////////////////////////////////////////

    localparam int xLen         = 32;
    localparam int regAddrWidth = 5;

    // reset values
    localparam logic [xLen-1:0] defaultResetPc = 32'h0000_0000;
    localparam logic [xLen-1:0] regResetValue  = '0;

    //////////////////////////////////////////////////////////////////////
    // encodings
    //////////////////////////////////////////////////////////////////////

    // major opcodes, instr[6:0]
    typedef enum logic [6:0] {
        opOp    = 7'b0110011,
        opOpImm = 7'b0010011,
        opLui   = 7'b0110111,
        opAuipc = 7'b0010111
    } opcodeT;

    typedef enum logic [3:0] {
        aluAdd   = 4'd0,
        aluSub   = 4'd1,
        aluSll   = 4'd2,
        aluSlt   = 4'd3,
        aluSltu  = 4'd4,
        aluXor   = 4'd5,
        aluSrl   = 4'd6,
        aluSra   = 4'd7,
        aluOr    = 4'd8,
        aluAnd   = 4'd9,
        aluPassB = 4'd10  // operand b straight through, for lui
    } aluOpT;

    // first operand source
    typedef enum logic [1:0] {
        srcRs1  = 2'd0,
        srcPc   = 2'd1,
        srcZero = 2'd2
    } srcASelT;

endpackage

/* logic/fetchUnit.sv */
module fetchUnit #(
    parameter int                          DecodeDepth = 4,
    parameter logic [rv32Pkg::xLen-1:0]    ResetPc     = rv32Pkg::defaultResetPc
) (
    input  logic                     Clk,
    input  logic                     reset,
    input  logic                     instrValid,
    input  logic [31:0]              instr,
    input  logic                     creditReturn,
    output logic                     instrReady,
    output logic                     fetchValid,
    output logic [31:0]              fetchInstr,
    output logic [rv32Pkg::xLen-1:0] fetchPc
);

    localparam int CreditWidth = $clog2(DecodeDepth + 1);

    logic [CreditWidth-1:0]   credits;
    logic [CreditWidth-1:0]   nextCredits;
    logic [rv32Pkg::xLen-1:0] pc;
    logic                     accept;

    assign accept = instrValid && instrReady;

    // one spent per accept, one back per returned entry
    always_comb begin
        nextCredits = credits;
        if (accept)
            nextCredits = nextCredits - 1'b1;
        if (creditReturn)
            nextCredits = nextCredits + 1'b1;
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            credits    <= CreditWidth'(DecodeDepth);
            instrReady <= 1'b0;
            fetchValid <= 1'b0;
            pc         <= ResetPc;
        end else begin
            credits    <= nextCredits;
            instrReady <= (nextCredits != '0);  // registered, tracks credits
            fetchValid <= accept;
            if (accept)
                pc <= pc + 32'd4;  // no redirects, counts up only
        end
    end

    // payload, no reset
    always_ff @(posedge Clk) begin
        if (accept) begin
            fetchInstr <= instr;
            fetchPc    <= pc;
        end
    end

    // decode queue must never hand back more than it was given
    creditBound: assert property (@(posedge Clk) disable iff (reset)
        credits <= CreditWidth'(DecodeDepth));

endmodule

/* logic/decodeControl.sv */
module decodeControl (
    input  logic [31:0]                      instr,
    output rv32Pkg::aluOpT                   aluOp,
    output rv32Pkg::srcASelT                 srcASel,
    output logic                             useImm,
    output logic [rv32Pkg::xLen-1:0]         immediate,
    output logic [rv32Pkg::regAddrWidth-1:0] rs1Addr,
    output logic [rv32Pkg::regAddrWidth-1:0] rs2Addr,
    output logic [rv32Pkg::regAddrWidth-1:0] rdAddr,
    output logic                             regWrite,
    output logic                             illegal
);

    rv32Pkg::opcodeT opcode;
    logic [2:0]      funct3;
    logic [6:0]      funct7;

    assign opcode  = rv32Pkg::opcodeT'(instr[6:0]);
    assign funct3  = instr[14:12];
    assign funct7  = instr[31:25];
    assign rs1Addr = instr[19:15];
    assign rs2Addr = instr[24:20];
    assign rdAddr  = instr[11:7];

    // shared by OP and OP-IMM, alt picks sub / sra
    function automatic rv32Pkg::aluOpT aluFromFunct3(input logic [2:0] f3, input logic alt);
        case (f3)
            3'b000:  return alt ? rv32Pkg::aluSub : rv32Pkg::aluAdd;
            3'b001:  return rv32Pkg::aluSll;
            3'b010:  return rv32Pkg::aluSlt;
            3'b011:  return rv32Pkg::aluSltu;
            3'b100:  return rv32Pkg::aluXor;
            3'b101:  return alt ? rv32Pkg::aluSra : rv32Pkg::aluSrl;
            3'b110:  return rv32Pkg::aluOr;
            default: return rv32Pkg::aluAnd;
        endcase
    endfunction

    always_comb begin
        aluOp     = rv32Pkg::aluAdd;
        srcASel   = rv32Pkg::srcRs1;
        useImm    = 1'b0;
        immediate = {{20{instr[31]}}, instr[31:20]};  // I-type by default
        regWrite  = 1'b1;
        illegal   = 1'b0;

        case (opcode)
            rv32Pkg::opOp: begin
                aluOp = aluFromFunct3(funct3, funct7[5]);
                // only add/sub and srl/sra have an alternate form
                if (funct7 == 7'b0100000)
                    illegal = (funct3 != 3'b000) && (funct3 != 3'b101);
                else
                    illegal = (funct7 != 7'b0000000);
            end
            rv32Pkg::opOpImm: begin
                useImm = 1'b1;
                aluOp  = aluFromFunct3(funct3, (funct3 == 3'b101) && funct7[5]);
                if (funct3 == 3'b001)
                    illegal = (funct7 != 7'b0000000);  // slli
                else if (funct3 == 3'b101)
                    illegal = (funct7 != 7'b0000000) && (funct7 != 7'b0100000);
            end
            rv32Pkg::opLui: begin
                aluOp     = rv32Pkg::aluPassB;
                srcASel   = rv32Pkg::srcZero;
                useImm    = 1'b1;
                immediate = {instr[31:12], 12'b0};
            end
            rv32Pkg::opAuipc: begin
                srcASel   = rv32Pkg::srcPc;
                useImm    = 1'b1;
                immediate = {instr[31:12], 12'b0};
            end
            default: illegal = 1'b1;
        endcase

        if (illegal)
            regWrite = 1'b0;
    end

endmodule

/* logic/registerFile.sv */
module registerFile (
    input  logic                             Clk,
    input  logic                             reset,
    input  logic [rv32Pkg::regAddrWidth-1:0] rs1Addr,
    input  logic [rv32Pkg::regAddrWidth-1:0] rs2Addr,
    input  logic                             wbEn,
    input  logic [rv32Pkg::regAddrWidth-1:0] wbAddr,
    input  logic [rv32Pkg::xLen-1:0]         wbData,
    output logic [rv32Pkg::xLen-1:0]         rs1Data,
    output logic [rv32Pkg::xLen-1:0]         rs2Data
);

    logic [rv32Pkg::xLen-1:0] regs [2**rv32Pkg::regAddrWidth];

    // x0 first, then write bypass, then array
    function automatic logic [rv32Pkg::xLen-1:0] readPort(
        input logic [rv32Pkg::regAddrWidth-1:0] addr
    );
        if (addr == '0)
            return '0;
        if (wbEn && (wbAddr == addr))
            return wbData;
        return regs[addr];
    endfunction

    always_comb begin
        rs1Data = readPort(rs1Addr);
        rs2Data = readPort(rs2Addr);
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            for (int i = 0; i < 2**rv32Pkg::regAddrWidth; i++)
                regs[i] <= rv32Pkg::regResetValue;
        end else if (wbEn && (wbAddr != '0)) begin
            regs[wbAddr] <= wbData;  // x0 never written
        end
    end

endmodule

/* logic/decodeStage.sv */
module decodeStage #(
    parameter int DecodeDepth = 4
) (
    input  logic                             Clk,
    input  logic                             reset,
    input  logic                             fetchValid,
    input  logic [31:0]                      fetchInstr,
    input  logic [rv32Pkg::xLen-1:0]         fetchPc,
    input  logic                             issueReady,
    input  logic                             wbEn,
    input  logic [rv32Pkg::regAddrWidth-1:0] wbAddr,
    input  logic [rv32Pkg::xLen-1:0]         wbData,
    output logic                             creditReturn,
    output logic                             issueValid,
    output rv32Pkg::aluOpT                   issueAluOp,
    output logic [rv32Pkg::xLen-1:0]         issueOperandA,
    output logic [rv32Pkg::xLen-1:0]         issueOperandB,
    output logic [rv32Pkg::regAddrWidth-1:0] issueRd,
    output logic                             issueRegWrite,
    output logic                             issueIllegal,
    output logic [rv32Pkg::xLen-1:0]         issuePc
);

    localparam int PtrWidth   = $clog2(DecodeDepth);
    localparam int CountWidth = $clog2(DecodeDepth + 1);

    rv32Pkg::aluOpT                   decAluOp;
    rv32Pkg::srcASelT                 decSrcASel;
    logic                             decUseImm, decRegWrite, decIllegal;
    logic [rv32Pkg::xLen-1:0]         decImm;
    logic [rv32Pkg::regAddrWidth-1:0] decRs1, decRs2, decRd;

    decodeControl decoder (
        .instr     (fetchInstr),
        .aluOp     (decAluOp),
        .srcASel   (decSrcASel),
        .useImm    (decUseImm),
        .immediate (decImm),
        .rs1Addr   (decRs1),
        .rs2Addr   (decRs2),
        .rdAddr    (decRd),
        .regWrite  (decRegWrite),
        .illegal   (decIllegal)
    );

    //////////////////////////////////////////////////////////////////////
    // decoded-operation queue
    //////////////////////////////////////////////////////////////////////

    rv32Pkg::aluOpT                   aluOpQ   [DecodeDepth];
    rv32Pkg::srcASelT                 srcASelQ [DecodeDepth];
    logic                             useImmQ  [DecodeDepth];
    logic                             regWrQ   [DecodeDepth];
    logic                             illegalQ [DecodeDepth];
    logic [rv32Pkg::xLen-1:0]         immQ     [DecodeDepth];
    logic [rv32Pkg::xLen-1:0]         pcQ      [DecodeDepth];
    logic [rv32Pkg::regAddrWidth-1:0] rs1Q     [DecodeDepth];
    logic [rv32Pkg::regAddrWidth-1:0] rs2Q     [DecodeDepth];
    logic [rv32Pkg::regAddrWidth-1:0] rdQ      [DecodeDepth];

    logic [PtrWidth-1:0]      wrPtr, rdPtr;
    logic [CountWidth-1:0]    count;
    logic                     issue;
    logic [rv32Pkg::xLen-1:0] rs1Data, rs2Data;

    assign issueValid   = (count != '0);
    assign issue        = issueValid && issueReady;
    assign creditReturn = issue;  // one credit per entry leaving

    always_ff @(posedge Clk) begin
        if (fetchValid) begin
            aluOpQ[wrPtr]   <= decAluOp;
            srcASelQ[wrPtr] <= decSrcASel;
            useImmQ[wrPtr]  <= decUseImm;
            regWrQ[wrPtr]   <= decRegWrite;
            illegalQ[wrPtr] <= decIllegal;
            immQ[wrPtr]     <= decImm;
            pcQ[wrPtr]      <= fetchPc;
            rs1Q[wrPtr]     <= decRs1;
            rs2Q[wrPtr]     <= decRs2;
            rdQ[wrPtr]      <= decRd;
        end
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            wrPtr <= '0;
            rdPtr <= '0;
            count <= '0;
        end else begin
            if (fetchValid)
                wrPtr <= (wrPtr == PtrWidth'(DecodeDepth - 1)) ? '0 : wrPtr + 1'b1;
            if (issue)
                rdPtr <= (rdPtr == PtrWidth'(DecodeDepth - 1)) ? '0 : rdPtr + 1'b1;
            if (fetchValid && !issue)
                count <= count + 1'b1;
            else if (!fetchValid && issue)
                count <= count - 1'b1;
        end
    end

    // register read at the head
    registerFile regFile (
        .Clk     (Clk),
        .reset   (reset),
        .rs1Addr (rs1Q[rdPtr]),
        .rs2Addr (rs2Q[rdPtr]),
        .wbEn    (wbEn),
        .wbAddr  (wbAddr),
        .wbData  (wbData),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    always_comb begin
        case (srcASelQ[rdPtr])
            rv32Pkg::srcRs1: issueOperandA = rs1Data;
            rv32Pkg::srcPc:  issueOperandA = pcQ[rdPtr];
            default:         issueOperandA = '0;
        endcase
    end

    assign issueOperandB = useImmQ[rdPtr] ? immQ[rdPtr] : rs2Data;
    assign issueAluOp    = aluOpQ[rdPtr];
    assign issueRd       = rdQ[rdPtr];
    assign issueRegWrite = regWrQ[rdPtr];
    assign issueIllegal  = illegalQ[rdPtr];
    assign issuePc       = pcQ[rdPtr];

    // credits in fetch must keep the queue from overflowing
    noOverflow: assert property (@(posedge Clk) disable iff (reset)
        fetchValid |-> (count < CountWidth'(DecodeDepth)));

endmodule

/* logic/executeUnit.sv */
module executeUnit (
    input  logic                             Clk,
    input  logic                             reset,
    input  logic                             issueValid,
    input  rv32Pkg::aluOpT                   issueAluOp,
    input  logic [rv32Pkg::xLen-1:0]         issueOperandA,
    input  logic [rv32Pkg::xLen-1:0]         issueOperandB,
    input  logic [rv32Pkg::regAddrWidth-1:0] issueRd,
    input  logic                             issueRegWrite,
    input  logic                             issueIllegal,
    input  logic [rv32Pkg::xLen-1:0]         issuePc,
    input  logic                             resultReady,
    output logic                             issueReady,
    output logic                             wbEn,
    output logic [rv32Pkg::regAddrWidth-1:0] wbAddr,
    output logic [rv32Pkg::xLen-1:0]         wbData,
    output logic                             resultValid,
    output logic [rv32Pkg::xLen-1:0]         resultPc,
    output logic [rv32Pkg::regAddrWidth-1:0] resultRd,
    output logic [rv32Pkg::xLen-1:0]         resultData,
    output logic                             resultWrote,
    output logic                             resultIllegal
);

    logic [rv32Pkg::xLen-1:0] aluResult;
    logic                     transfer, writes;
    logic [4:0]               shamt;

    assign issueReady = !resultValid || resultReady;  // empty or emptying now
    assign transfer   = issueValid && issueReady;
    assign writes     = issueRegWrite && !issueIllegal && (issueRd != '0);
    assign shamt      = issueOperandB[4:0];

    always_comb begin
        case (issueAluOp)
            rv32Pkg::aluAdd:  aluResult = issueOperandA + issueOperandB;
            rv32Pkg::aluSub:  aluResult = issueOperandA - issueOperandB;
            rv32Pkg::aluSll:  aluResult = issueOperandA << shamt;
            rv32Pkg::aluSlt:
                aluResult = {31'b0, $signed(issueOperandA) < $signed(issueOperandB)};
            rv32Pkg::aluSltu: aluResult = {31'b0, issueOperandA < issueOperandB};
            rv32Pkg::aluXor:  aluResult = issueOperandA ^ issueOperandB;
            rv32Pkg::aluSrl:  aluResult = issueOperandA >> shamt;
            rv32Pkg::aluSra:  aluResult = $unsigned($signed(issueOperandA) >>> shamt);
            rv32Pkg::aluOr:   aluResult = issueOperandA | issueOperandB;
            rv32Pkg::aluAnd:  aluResult = issueOperandA & issueOperandB;
            default:          aluResult = issueOperandB;  // passB
        endcase
    end

    always_ff @(posedge Clk) begin
        if (reset) begin
            resultValid <= 1'b0;
            wbEn        <= 1'b0;
        end else begin
            wbEn <= transfer && writes;  // single-cycle write pulse
            if (transfer)
                resultValid <= 1'b1;
            else if (resultReady)
                resultValid <= 1'b0;
        end
    end

    // held result, payload only
    always_ff @(posedge Clk) begin
        if (transfer) begin
            resultPc      <= issuePc;
            resultRd      <= issueRd;
            resultData    <= aluResult;
            resultWrote   <= writes;
            resultIllegal <= issueIllegal;
        end
    end

    // writeback shares the result register, regfile bypass covers the next issue
    assign wbAddr = resultRd;
    assign wbData = resultData;

    resultHeld: assert property (@(posedge Clk) disable iff (reset)
        resultValid && !resultReady |=> resultValid && $stable(resultData)
            && $stable(resultPc) && $stable(resultRd) && $stable(resultWrote)
            && $stable(resultIllegal));

endmodule

/* logic/rv32Slice.sv */
module rv32Slice #(
    parameter int                       DecodeDepth = 4,
    parameter logic [rv32Pkg::xLen-1:0] ResetPc     = rv32Pkg::defaultResetPc
) (
    input  logic                             Clk,
    input  logic                             reset,
    input  logic                             instrValid,
    input  logic [31:0]                      instr,
    output logic                             instrReady,
    input  logic                             resultReady,
    output logic                             resultValid,
    output logic [rv32Pkg::xLen-1:0]         resultPc,
    output logic [rv32Pkg::regAddrWidth-1:0] resultRd,
    output logic [rv32Pkg::xLen-1:0]         resultData,
    output logic                             resultWrote,
    output logic                             resultIllegal
);

    // fetch to decode
    logic                             fetchValid, creditReturn;
    logic [31:0]                      fetchInstr;
    logic [rv32Pkg::xLen-1:0]         fetchPc;

    // decode to execute
    logic                             issueValid, issueReady;
    rv32Pkg::aluOpT                   issueAluOp;
    logic [rv32Pkg::xLen-1:0]         issueOperandA, issueOperandB, issuePc;
    logic [rv32Pkg::regAddrWidth-1:0] issueRd;
    logic                             issueRegWrite, issueIllegal;

    // writeback
    logic                             wbEn;
    logic [rv32Pkg::regAddrWidth-1:0] wbAddr;
    logic [rv32Pkg::xLen-1:0]         wbData;

    fetchUnit #(.DecodeDepth(DecodeDepth), .ResetPc(ResetPc)) fetch (
        .Clk(Clk), .reset(reset),
        .instrValid(instrValid), .instr(instr), .creditReturn(creditReturn),
        .instrReady(instrReady), .fetchValid(fetchValid),
        .fetchInstr(fetchInstr), .fetchPc(fetchPc)
    );

    decodeStage #(.DecodeDepth(DecodeDepth)) decode (
        .Clk(Clk), .reset(reset),
        .fetchValid(fetchValid), .fetchInstr(fetchInstr), .fetchPc(fetchPc),
        .issueReady(issueReady), .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .creditReturn(creditReturn), .issueValid(issueValid), .issueAluOp(issueAluOp),
        .issueOperandA(issueOperandA), .issueOperandB(issueOperandB),
        .issueRd(issueRd), .issueRegWrite(issueRegWrite),
        .issueIllegal(issueIllegal), .issuePc(issuePc)
    );

    executeUnit execute (
        .Clk(Clk), .reset(reset),
        .issueValid(issueValid), .issueAluOp(issueAluOp),
        .issueOperandA(issueOperandA), .issueOperandB(issueOperandB),
        .issueRd(issueRd), .issueRegWrite(issueRegWrite),
        .issueIllegal(issueIllegal), .issuePc(issuePc),
        .resultReady(resultReady), .issueReady(issueReady),
        .wbEn(wbEn), .wbAddr(wbAddr), .wbData(wbData),
        .resultValid(resultValid), .resultPc(resultPc), .resultRd(resultRd),
        .resultData(resultData), .resultWrote(resultWrote),
        .resultIllegal(resultIllegal)
    );

endmodule

/* verification/sliceTests.svh */
//////////////////////////////////////////////////////////////////////
// encoders and reference model
//////////////////////////////////////////////////////////////////////

function automatic logic [31:0] encR(input logic [6:0] f7, input logic [4:0] rs2, rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
    return {f7, rs2, rs1, f3, rd, rv32Pkg::opOp};
endfunction

function automatic logic [31:0] encI(input logic [11:0] imm, input logic [4:0] rs1,
                                     input logic [2:0] f3, input logic [4:0] rd);
    return {imm, rs1, f3, rd, rv32Pkg::opOpImm};
endfunction

function automatic logic [31:0] encU(input logic [6:0] op, input logic [19:0] imm,
                                     input logic [4:0] rd);
    return {imm, rd, op};
endfunction

function automatic logic [31:0] aluRef(input rv32Pkg::aluOpT op, input logic [31:0] a, b);
    case (op)
        rv32Pkg::aluAdd:  return a + b;
        rv32Pkg::aluSub:  return a - b;
        rv32Pkg::aluSll:  return a << b[4:0];
        rv32Pkg::aluSlt:  return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
        rv32Pkg::aluSltu: return (a < b) ? 32'd1 : 32'd0;
        rv32Pkg::aluXor:  return a ^ b;
        rv32Pkg::aluSrl:  return a >> b[4:0];
        rv32Pkg::aluSra:  return 32'($signed(a) >>> b[4:0]);
        rv32Pkg::aluOr:   return a | b;
        default:          return a & b;
    endcase
endfunction

// model one instruction in program order
task automatic expectInstr(input logic [31:0] word);
    logic [6:0]     opcode, f7;
    logic [2:0]     f3;
    logic [31:0]    a, data;
    logic           illegal, alt;
    rv32Pkg::aluOpT op;
    opcode  = word[6:0];
    f3      = word[14:12];
    f7      = word[31:25];
    alt     = (f7 == 7'h20);
    a       = refRegs[word[19:15]];
    illegal = 1'b0;
    data    = '0;
    case (f3)
        3'b000:  op = (alt && opcode == rv32Pkg::opOp) ? rv32Pkg::aluSub : rv32Pkg::aluAdd;
        3'b001:  op = rv32Pkg::aluSll;
        3'b010:  op = rv32Pkg::aluSlt;
        3'b011:  op = rv32Pkg::aluSltu;
        3'b100:  op = rv32Pkg::aluXor;
        3'b101:  op = alt ? rv32Pkg::aluSra : rv32Pkg::aluSrl;
        3'b110:  op = rv32Pkg::aluOr;
        default: op = rv32Pkg::aluAnd;
    endcase
    case (opcode)
        rv32Pkg::opOp: begin
            illegal = !(f7 == 7'h00 || (alt && (f3 == 3'b000 || f3 == 3'b101)));
            data    = aluRef(op, a, refRegs[word[24:20]]);
        end
        rv32Pkg::opOpImm: begin
            if (f3 == 3'b001)
                illegal = (f7 != 7'h00);  // slli takes no alternate form
            else if (f3 == 3'b101)
                illegal = !(f7 == 7'h00 || alt);
            data = aluRef(op, a, {{20{word[31]}}, word[31:20]});
        end
        rv32Pkg::opLui:   data = {word[31:12], 12'b0};
        rv32Pkg::opAuipc: data = expPc + {word[31:12], 12'b0};
        default:          illegal = 1'b1;
    endcase
    pcQ.push_back(expPc);
    dataQ.push_back(data);
    rdQ.push_back(word[11:7]);
    illegalQ.push_back(illegal);
    wroteQ.push_back(!illegal && word[11:7] != 5'd0);
    if (!illegal && word[11:7] != 5'd0)
        refRegs[word[11:7]] = data;
    expPc = expPc + 32'd4;
endtask

//////////////////////////////////////////////////////////////////////
// driver and test bookkeeping
//////////////////////////////////////////////////////////////////////

task automatic applyReset();
    reset = 1'b1;
    repeat (16) @(posedge Clk);
    #1;
    reset = 1'b0;
    foreach (refRegs[i])
        refRegs[i] = '0;
    pcQ.delete();
    dataQ.delete();
    rdQ.delete();
    wroteQ.delete();
    illegalQ.delete();
    expPc = ResetPc;
endtask

// held until fetch takes it
task automatic sendInstr(input logic [31:0] word);
    instrValid = 1'b1;
    instr      = word;
    @(posedge Clk);
    while (!instrReady)
        @(posedge Clk);
    expectInstr(word);
    #1;
    instrValid = 1'b0;  // next send in the same step keeps it high
endtask

task automatic finishTest(input string name, input int startErrors);
    int waited;
    waited = 0;
    while (pcQ.size() != 0 && waited < 200) begin
        @(posedge Clk);
        #1;
        waited++;
    end
    if (pcQ.size() != 0) begin
        $display("%s: %0d instructions never retired", name, pcQ.size());
        errorCount++;
    end
    testCount++;
    $display("test %-14s %s, %0d errors", name,
             (errorCount == startErrors) ? "ok" : "failed", errorCount - startErrors);
endtask

// lui then addi, upper half rounded for the sign-extended low part
task automatic loadReg(input logic [4:0] rd, input logic [31:0] value);
    logic [31:0] upper;
    upper = value + 32'h800;
    sendInstr(encU(rv32Pkg::opLui, upper[31:12], rd));
    sendInstr(encI(value[11:0], rd, 3'b000, rd));
endtask

//////////////////////////////////////////////////////////////////////
// directed tests
//////////////////////////////////////////////////////////////////////

task automatic resetStateTest();
    int startErrors;
    startErrors = errorCount;
    applyReset();
    @(posedge Clk);  // outputs still hold reset values here
    if (instrReady !== 1'b0 || resultValid !== 1'b0) begin
        $display("mismatch at %0t: instrReady %b resultValid %b right after reset",
                 $time, instrReady, resultValid);
        errorCount++;
    end
    #1;
    if (instrReady !== 1'b1) begin
        $display("mismatch at %0t: instrReady did not rise one cycle after reset", $time);
        errorCount++;
    end
    for (int r = 1; r < 32; r++)
        sendInstr(encI(12'd0, 5'(r), 3'b000, 5'(r)));  // addi xr, xr, 0
    finishTest("resetState", startErrors);
endtask

task automatic immediateTest();
    int startErrors;
    startErrors = errorCount;
    sendInstr(encI(12'd5, 5'd0, 3'b000, 5'd1));
    sendInstr(encI(12'h0f0, 5'd1, 3'b100, 5'd2));  // xori
    sendInstr(encI(12'hfff, 5'd1, 3'b010, 5'd3));  // slti against -1
    sendInstr(encI(12'hfff, 5'd1, 3'b011, 5'd4));  // sltiu, -1 is the largest
    sendInstr(encI(12'h800, 5'd0, 3'b000, 5'd5));
    sendInstr(encU(rv32Pkg::opLui, 20'h12345, 5'd6));
    sendInstr(encU(rv32Pkg::opAuipc, 20'h00001, 5'd7));
    finishTest("immediate", startErrors);
endtask

task automatic registerOpTest();
    int          startErrors;
    logic [31:0] a, b;
    startErrors = errorCount;
    for (int round = 0; round < 4; round++) begin
        a = $urandom();
        b = $urandom();
        if (round[0]) begin
            a[31] = 1'b1;  // slt and sltu must disagree
            b[31] = 1'b0;
        end
        loadReg(5'd10, a);
        loadReg(5'd11, b);
        for (int k = 0; k < 8; k++)
            sendInstr(encR(7'h00, 5'd11, 5'd10, 3'(k), 5'(12 + k)));
        sendInstr(encR(7'h20, 5'd11, 5'd10, 3'b000, 5'd20));  // sub
        sendInstr(encR(7'h20, 5'd11, 5'd10, 3'b101, 5'd21));  // sra
    end
    finishTest("registerOp", startErrors);
endtask

// each instruction reads the one just before it
task automatic dependenceTest();
    int startErrors;
    startErrors = errorCount;
    sendInstr(encI(12'd1, 5'd0, 3'b000, 5'd7));
    for (int i = 0; i < 16; i++) begin
        case (i % 4)
            0:       sendInstr(encI(12'($urandom()), 5'd7, 3'b000, 5'd7));
            1:       sendInstr(encR(7'h00, 5'd7, 5'd7, 3'b000, 5'd8));
            2:       sendInstr(encR(7'h20, 5'd7, 5'd8, 3'b101, 5'd7));
            default: sendInstr(encI(12'($urandom()), 5'd7, 3'b100, 5'd7));
        endcase
    end
    finishTest("dependence", startErrors);
endtask

task automatic backPressureTest();
    int          startErrors, accepts;
    logic [31:0] word;
    logic        sawLow;
    startErrors = errorCount;
    accepts     = 0;
    sawLow      = 1'b0;
    resultReady = 1'b0;
    word        = encI(12'($urandom()), 5'd0, 3'b000, 5'd22);
    for (int c = 0; c < 20; c++) begin
        instrValid = 1'b1;
        instr      = word;
        @(posedge Clk);
        if (instrReady) begin
            expectInstr(word);
            accepts++;
            word = encI(12'($urandom()), 5'(21 + accepts % 8), 3'b000, 5'(22 + accepts % 8));
        end else
            sawLow = 1'b1;
        #1;
    end
    instrValid = 1'b0;
    if (!sawLow) begin
        $display("instrReady never fell during the stall");
        errorCount++;
    end
    if (accepts > DecodeDepth + 2) begin
        $display("mismatch at %0t: %0d accepts while stalled, limit %0d",
                 $time, accepts, DecodeDepth + 2);
        errorCount++;
    end
    resultReady = 1'b1;
    for (int i = 0; i < 4; i++)
        sendInstr(encI(12'(i), 5'd22, 3'b000, 5'd22));
    finishTest("backPressure", startErrors);
endtask

task automatic illegalAndX0Test();
    int startErrors;
    startErrors = errorCount;
    sendInstr(32'hffff_ffff);                           // unknown opcode
    sendInstr(encR(7'h01, 5'd2, 5'd1, 3'b000, 5'd9));   // mul encoding, not supported
    sendInstr(encI(12'd123, 5'd0, 3'b000, 5'd0));
    sendInstr(encU(rv32Pkg::opLui, 20'hfffff, 5'd0));
    sendInstr(encR(7'h00, 5'd0, 5'd0, 3'b110, 5'd9));   // x0 must still read zero
    sendInstr(encI(12'd0, 5'd0, 3'b000, 5'd10));
    finishTest("illegalAndX0", startErrors);
endtask

/* verification/sliceTb.sv */
module sliceTb;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int          DecodeDepth = 4;
    localparam logic [31:0] ResetPc     = 32'h0000_0100;
    localparam int          MaxCycles   = 4000;  // tests need a few hundred, ample margin

    logic        Clk = 1'b0;
    logic        reset;
    logic        instrValid;
    logic [31:0] instr;
    logic        instrReady;
    logic        resultReady;
    logic        resultValid;
    logic [31:0] resultPc;
    logic [4:0]  resultRd;
    logic [31:0] resultData;
    logic        resultWrote;
    logic        resultIllegal;

    // reference model and expected results, oldest first
    logic [31:0] refRegs [32];
    logic [31:0] expPc;
    logic [31:0] pcQ[$];
    logic [31:0] dataQ[$];
    logic [4:0]  rdQ[$];
    logic        wroteQ[$];
    logic        illegalQ[$];
    int          errorCount, resultCount, testCount;
    int          cycleCount = 0;

    rv32Slice #(.DecodeDepth(DecodeDepth), .ResetPc(ResetPc)) dut_i (
        .Clk(Clk), .reset(reset),
        .instrValid(instrValid), .instr(instr), .instrReady(instrReady),
        .resultReady(resultReady), .resultValid(resultValid), .resultPc(resultPc),
        .resultRd(resultRd), .resultData(resultData), .resultWrote(resultWrote),
        .resultIllegal(resultIllegal)
    );

    always #2 Clk = ~Clk;

    always @(posedge Clk) begin
        cycleCount++;
        if (cycleCount >= MaxCycles) begin
            $display("timeout: run did not finish within %0d cycles", MaxCycles);
            $display("** FAIL **");
            $finish;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // result monitor
    //////////////////////////////////////////////////////////////////////

    task automatic checkField(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s expected %h got %h", $time, name, exp, got);
            errorCount++;
        end
    endtask

    task automatic compareResult();
        logic [31:0] pcExp, dataExp;
        logic [4:0]  rdExp;
        logic        wroteExp, illegalExp;
        pcExp      = pcQ.pop_front();
        dataExp    = dataQ.pop_front();
        rdExp      = rdQ.pop_front();
        wroteExp   = wroteQ.pop_front();
        illegalExp = illegalQ.pop_front();
        checkField("pc", resultPc, pcExp);
        checkField("rd", resultRd, rdExp);
        checkField("wrote", resultWrote, wroteExp);
        checkField("illegal", resultIllegal, illegalExp);
        if (wroteExp)
            checkField("data", resultData, dataExp);  // data is don't-care without a write
    endtask

    always @(posedge Clk) begin
        if (!reset && resultValid && resultReady) begin
            resultCount++;
            if (pcQ.size() == 0) begin
                $display("result at %0t with nothing outstanding, pc %h", $time, resultPc);
                errorCount++;
            end else
                compareResult();
        end
    end

    `include "sliceTests.svh"

    initial begin
        instrValid  = 1'b0;
        instr       = '0;
        resultReady = 1'b1;
        reset       = 1'b1;
        errorCount  = 0;
        resultCount = 0;
        testCount   = 0;
        void'($urandom(32'ha1b5));
        resetStateTest();
        immediateTest();
        registerOpTest();
        dependenceTest();
        backPressureTest();
        illegalAndX0Test();
        $display("totals: %0d tests, %0d results, %0d errors",
                 testCount, resultCount, errorCount);
        if (errorCount == 0)
            $display("** PASS **");
        else
            $display("** FAIL **");
        $finish;
    end

endmodule

/* sim.f */
+incdir+verification
logic/rv32Pkg.sv
logic/fetchUnit.sv
logic/decodeControl.sv
logic/registerFile.sv
logic/decodeStage.sv
logic/executeUnit.sv
logic/rv32Slice.sv
verification/sliceTb.sv
